// ==== Makefile ====
# Verilator flow for the function-unit block and its testbench.

VERILATOR ?= verilator
TOP ?= fu_main_tb
RTL_TOP ?= fu_main
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter verilog/%,$(SOURCES))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SOURCES) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported a failure."; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation ended without a pass."; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
verilog/fu_pkg.sv
verilog/int_alu.sv
verilog/br_alu.sv
verilog/mult_ctrl.sv
verilog/mult_step_counter.sv
verilog/mult_datapath.sv
verilog/fu_main.sv
test/fu_main_props.sv
test/fu_main_tb.sv

// ==== test/fu_main_props.sv ====
`timescale 1ns/1ps

module fu_main_props (
	input logic clk,
	input logic rst,
	input logic alu_start_i,
	input logic br_start_i,
	input logic alu_done_i,
	input logic br_done_i,
	input logic mult_done_i,
	input logic mult_load_i,
	input logic busy_i,
	input logic block_i,
	input logic wr_en_i,
	input fu_pkg::prf_idx_t wr_tag_i,
	input logic cdb_valid_i,
	input fu_pkg::prf_idx_t cdb_tag_i
);
	int fail_cnt = 0;

	one_done: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_done_i, br_done_i, mult_done_i}))
	else begin
		fail_cnt++;
		$error("More than one unit completed in the same cycle.");
	end

	no_start_blocked: assert property (@(posedge clk) disable iff (rst)
		block_i |-> !(alu_start_i || br_start_i))
	else begin
		fail_cnt++;
		$error("ALU or branch unit started while issue was blocked.");
	end

	// Busy must hold from the cycle after the load through the WB cycle.
	busy_after_load: assert property (@(posedge clk) disable iff (rst)
		mult_load_i |=> busy_i)
	else begin
		fail_cnt++;
		$error("Multiplier busy missing after a multiply was accepted.");
	end

	busy_until_done: assert property (@(posedge clk) disable iff (rst)
		(busy_i && !mult_done_i) |=> busy_i)
	else begin
		fail_cnt++;
		$error("Multiplier busy dropped before the multiply completed.");
	end

	cdb_follows_write: assert property (@(posedge clk) disable iff (rst)
		wr_en_i |=> (cdb_valid_i && cdb_tag_i == $past(wr_tag_i)))
	else begin
		fail_cnt++;
		$error("Register write was not broadcast with its tag one cycle later.");
	end

endmodule

bind fu_main fu_main_props u_props (
	.clk(clk),
	.rst(rst),
	.alu_start_i(alu_start),
	.br_start_i(br_start),
	.alu_done_i(alu_done),
	.br_done_i(br_done),
	.mult_done_i(mult_done),
	.mult_load_i(mult_load),
	.busy_i(fu2rs_mult_busy_o),
	.block_i(fu2rs_issue_block_o),
	.wr_en_i(fu2preg_wr_en_o),
	.wr_tag_i(fu2preg_wr_o.idx),
	.cdb_valid_i(fu_cdb_valid_o),
	.cdb_tag_i(fu_cdb_tag_o)
);

// ==== test/fu_main_tb.sv ====
`timescale 1ns/1ps

module fu_main_tb;
	import fu_pkg::*;

	localparam int NUM_SLOTS = 600;
	localparam int CYCLE_LIMIT = 40 * NUM_SLOTS + 100;
	localparam int SHORT_LAT = 1;
	localparam int MULT_LAT = 33;

	typedef struct packed {
		fu_sel_t unit;
		fu_result_t res;
		logic [31:0] due;
	} exp_entry_t;

	logic clk;
	logic rst;
	logic issue_valid;
	fu_issue_t issue;
	logic wr_en;
	fu_wb_t wr;
	logic rob_done;
	fu_rob_t rob;
	logic cdb_valid;
	prf_idx_t cdb_tag;
	logic mult_busy;
	logic issue_block;

	logic [31:0] seed;
	int cycle_cnt = 0;
	int mult_issue_at = -1;
	int mult_cnt = 0;
	exp_entry_t exp_q[$];
	logic prev_wr_en = 1'b0;
	prf_idx_t prev_tag = '0;

	fu_main uut (
		.clk(clk),
		.rst(rst),
		.issue_valid_i(issue_valid),
		.issue_i(issue),
		.fu2preg_wr_en_o(wr_en),
		.fu2preg_wr_o(wr),
		.fu2rob_done_o(rob_done),
		.fu2rob_o(rob),
		.fu_cdb_valid_o(cdb_valid),
		.fu_cdb_tag_o(cdb_tag),
		.fu2rs_mult_busy_o(mult_busy),
		.fu2rs_issue_block_o(issue_block)
	);

	initial clk = 1'b0;

	always #20 clk = ~clk;

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("The run did not finish within %0d cycles.", CYCLE_LIMIT);
			stop_with_failure();
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic word_t rand_word();
		word_t w;
		w[63:32] = next_rand();
		w[31:0] = next_rand();
		return w;
	endfunction

	// Busy spans the run and write-back cycles after a multiply issue.
	function automatic logic busy_expected();
		return (mult_issue_at >= 0) && (cycle_cnt > mult_issue_at)
			&& (cycle_cnt <= mult_issue_at + MULT_LAT);
	endfunction

	function automatic logic block_expected();
		return (mult_issue_at >= 0) && (cycle_cnt == mult_issue_at + MULT_LAT - 1);
	endfunction

	function automatic alu_func_t pick_func(logic [3:0] k, alu_func_t other);
		case (k)
			4'd0: return ALU_ADD;
			4'd1: return ALU_SUB;
			4'd2: return ALU_AND;
			4'd3: return ALU_OR;
			4'd4: return ALU_XOR;
			4'd5: return ALU_SLL;
			4'd6: return ALU_SRL;
			4'd7: return ALU_SRA;
			4'd8: return ALU_CMPEQ;
			4'd9: return ALU_CMPULT;
			default: return other;
		endcase
	endfunction

	function automatic fu_issue_t random_issue();
		fu_issue_t iss;
		logic [31:0] r;
		r = next_rand();
		case (r[31:29])
			3'd0, 3'd1, 3'd2: iss.sel = FU_SEL_ALU;
			3'd3, 3'd4: iss.sel = FU_SEL_BR;
			3'd5: iss.sel = FU_SEL_MULT;
			3'd6: iss.sel = r[28] ? FU_SEL_LOAD : FU_SEL_NONE;
			default: iss.sel = FU_SEL_STORE;
		endcase
		iss.inst = next_rand();
		iss.inst[11:5] = pick_func(r[27:24], r[16:10]);
		iss.npc = rand_word();
		iss.npc[1:0] = 2'b00;
		iss.ra = rand_word();
		iss.rb = rand_word();
		// Zero and equal operands make the EQ tests and zero products likely.
		if (r[23:22] == 2'b00) begin
			iss.ra = '0;
		end
		if (r[21:20] == 2'b00) begin
			iss.rb = iss.ra;
		end
		iss.dest_tag = r[19:14];
		iss.rob_idx = r[13:9];
		return iss;
	endfunction

	function automatic fu_result_t expected_result(fu_issue_t iss);
		fu_result_t r;
		logic [5:0] sh;
		word_t ones;
		logic signed [22:0] offset;
		r = '0;
		sh = iss.rb[5:0];
		ones = '1;
		offset = {iss.inst[20:0], 2'b00};
		r.rob_idx = iss.rob_idx;
		if (iss.sel == FU_SEL_ALU) begin
			r.dest_tag = iss.dest_tag;
			case (iss.inst[11:5])
				ALU_ADD: r.value = iss.ra + iss.rb;
				ALU_SUB: r.value = iss.ra - iss.rb;
				ALU_AND: r.value = iss.ra & iss.rb;
				ALU_OR: r.value = iss.ra | iss.rb;
				ALU_XOR: r.value = iss.ra ^ iss.rb;
				ALU_SLL: r.value = iss.ra << sh;
				ALU_SRL: r.value = iss.ra >> sh;
				ALU_SRA: r.value = iss.ra[63] ? ((iss.ra >> sh) | ~(ones >> sh))
					: (iss.ra >> sh);
				ALU_CMPEQ: r.value = (iss.ra == iss.rb) ? 64'd1 : 64'd0;
				ALU_CMPULT: r.value = (iss.ra < iss.rb) ? 64'd1 : 64'd0;
				default: r.value = '0;
			endcase
		end else if (iss.sel == FU_SEL_BR) begin
			r.br_target = iss.npc + 64'(offset);
			case (iss.inst[28:26])
				BR_ALWAYS: r.br_taken = 1'b1;
				BR_EQ: r.br_taken = (iss.ra == 64'd0);
				BR_NE: r.br_taken = (iss.ra != 64'd0);
				BR_LT: r.br_taken = ($signed(iss.ra) < 0);
				BR_GE: r.br_taken = ($signed(iss.ra) >= 0);
				default: r.br_taken = 1'b0;
			endcase
		end else begin
			r.dest_tag = iss.dest_tag;
			r.value = iss.ra * iss.rb;
		end
		return r;
	endfunction

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_wb(fu_wb_t got, fu_wb_t exp);
		if (got !== exp) begin
			$display("** Error: fu2preg_wr_o idx=%h value=%h, expected idx=%h value=%h",
				got.idx, got.value, exp.idx, exp.value);
			stop_with_failure();
		end
	endtask

	task automatic check_rob(fu_rob_t got, fu_rob_t exp);
		if (got !== exp) begin
			$display("** Error: fu2rob_o rob_idx=%h taken=%h target=%h, expected %h %h %h",
				got.rob_idx, got.br_taken, got.br_target,
				exp.rob_idx, exp.br_taken, exp.br_target);
			stop_with_failure();
		end
	endtask

	task automatic check_tag(prf_idx_t got, prf_idx_t exp);
		if (got !== exp) begin
			$display("** Error: fu_cdb_tag_o = %h, expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	// Expectations are kept in completion order, which differs from issue order.
	task automatic drive_slot();
		fu_issue_t iss;
		exp_entry_t e;
		logic [31:0] r;
		logic go;
		logic known_unit;
		int idx;
		iss = random_issue();
		r = next_rand();
		go = (r[31:30] != 2'b00);
		if (iss.sel == FU_SEL_MULT && busy_expected()) begin
			go = 1'b0;
		end
		if ((iss.sel == FU_SEL_ALU || iss.sel == FU_SEL_BR) && block_expected()) begin
			go = 1'b0;
		end
		issue_valid = go;
		issue = iss;
		known_unit = (iss.sel == FU_SEL_ALU || iss.sel == FU_SEL_BR
			|| iss.sel == FU_SEL_MULT);
		if (go && known_unit) begin
			e.unit = iss.sel;
			e.res = expected_result(iss);
			e.due = 32'(cycle_cnt + ((iss.sel == FU_SEL_MULT) ? MULT_LAT : SHORT_LAT));
			if (iss.sel == FU_SEL_MULT) begin
				mult_issue_at = cycle_cnt;
				mult_cnt++;
			end
			idx = exp_q.size();
			while (idx > 0 && exp_q[idx-1].due > e.due) begin
				idx--;
			end
			exp_q.insert(idx, e);
		end
	endtask

	task automatic check_outputs();
		exp_entry_t e;
		fu_rob_t exp_rob;
		fu_wb_t exp_wb;
		logic exp_wr;
		prf_idx_t exp_tag;
		exp_wr = 1'b0;
		exp_tag = '0;
		if (uut.u_props.fail_cnt != 0) begin
			$display("A bound assertion on the DUT failed in cycle %0d.", cycle_cnt);
			stop_with_failure();
		end
		if (exp_q.size() > 0 && exp_q[0].due == 32'(cycle_cnt)) begin
			e = exp_q.pop_front();
			check_flag("fu2rob_done_o", rob_done, 1'b1);
			exp_rob.rob_idx = e.res.rob_idx;
			exp_rob.br_taken = e.res.br_taken;
			exp_rob.br_target = e.res.br_target;
			check_rob(rob, exp_rob);
			if (e.unit != FU_SEL_BR) begin
				exp_wr = 1'b1;
				exp_tag = e.res.dest_tag;
				exp_wb.idx = e.res.dest_tag;
				exp_wb.value = e.res.value;
				check_wb(wr, exp_wb);
			end
		end else begin
			check_flag("fu2rob_done_o", rob_done, 1'b0);
		end
		check_flag("fu2preg_wr_en_o", wr_en, exp_wr);
		check_flag("fu_cdb_valid_o", cdb_valid, prev_wr_en);
		if (prev_wr_en) begin
			check_tag(cdb_tag, prev_tag);
		end
		prev_wr_en = exp_wr;
		prev_tag = exp_tag;
		check_flag("fu2rs_mult_busy_o", mult_busy, busy_expected());
		check_flag("fu2rs_issue_block_o", issue_block, block_expected());
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			check_outputs();
		end
	end

	initial begin
		seed = 32'd96389;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// A few quiet cycles show the outputs idle after reset.
		repeat (4) @(negedge clk);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			drive_slot();
			@(negedge clk);
		end
		issue_valid = 1'b0;
		issue = '0;
		while (exp_q.size() > 0 || mult_busy) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		if (mult_cnt > 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("The random stimulus issued no multiply.");
			stop_with_failure();
		end
	end

endmodule

// ==== verilog/br_alu.sv ====
`timescale 1ns/1ps

module br_alu (
	input logic clk,
	input logic rst,
	input logic start_i,
	input fu_pkg::word_t npc_i,
	input fu_pkg::word_t opa_i,
	input fu_pkg::inst_t inst_i,
	input fu_pkg::rob_idx_t rob_idx_i,
	output logic done_o,
	output fu_pkg::fu_result_t result_o
);
	import fu_pkg::*;

	br_cond_t cond;
	word_t disp;
	logic taken_nxt;
	logic taken_r;
	word_t target_r;
	rob_idx_t rob_idx_r;

	assign cond = inst_i[28:26];
	// Word displacement, sign-extended and scaled to bytes.
	assign disp = {{41{inst_i[20]}}, inst_i[20:0], 2'b00};

	always_comb begin
		case (cond)
			BR_ALWAYS: taken_nxt = 1'b1;
			BR_EQ: taken_nxt = (opa_i == '0);
			BR_NE: taken_nxt = (opa_i != '0);
			BR_LT: taken_nxt = opa_i[WORD_W-1];
			BR_GE: taken_nxt = ~opa_i[WORD_W-1];
			default: taken_nxt = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			taken_r <= taken_nxt;
			target_r <= npc_i + disp;
			rob_idx_r <= rob_idx_i;
		end
	end

	always_comb begin
		result_o.value = '0;
		result_o.dest_tag = '0;
		result_o.rob_idx = rob_idx_r;
		result_o.br_taken = taken_r;
		result_o.br_target = target_r;
	end

endmodule

// ==== verilog/fu_main.sv ====
`timescale 1ns/1ps

module fu_main (
	input logic clk,
	input logic rst,
	input logic issue_valid_i,
	input fu_pkg::fu_issue_t issue_i,
	output logic fu2preg_wr_en_o,
	output fu_pkg::fu_wb_t fu2preg_wr_o,
	output logic fu2rob_done_o,
	output fu_pkg::fu_rob_t fu2rob_o,
	output logic fu_cdb_valid_o,
	output fu_pkg::prf_idx_t fu_cdb_tag_o,
	output logic fu2rs_mult_busy_o,
	output logic fu2rs_issue_block_o
);
	import fu_pkg::*;

	logic alu_start;
	logic br_start;
	logic mult_start;
	logic alu_done;
	logic br_done;
	logic mult_done;
	logic mult_load;
	logic mult_step;
	logic mult_last;
	fu_result_t alu_res;
	fu_result_t br_res;
	fu_result_t mult_res;
	fu_result_t done_res;

	// Load and store selects have no unit here and fall through with none.
	always_comb begin
		alu_start = 1'b0;
		br_start = 1'b0;
		mult_start = 1'b0;
		case (issue_i.sel)
			FU_SEL_ALU: alu_start = issue_valid_i;
			FU_SEL_BR: br_start = issue_valid_i;
			FU_SEL_MULT: mult_start = issue_valid_i;
			FU_SEL_NONE, FU_SEL_LOAD, FU_SEL_STORE: ;
			default: ;
		endcase
	end

	int_alu u_int_alu (
		.clk(clk),
		.rst(rst),
		.start_i(alu_start),
		.opa_i(issue_i.ra),
		.opb_i(issue_i.rb),
		.inst_i(issue_i.inst),
		.dest_tag_i(issue_i.dest_tag),
		.rob_idx_i(issue_i.rob_idx),
		.done_o(alu_done),
		.result_o(alu_res)
	);

	br_alu u_br_alu (
		.clk(clk),
		.rst(rst),
		.start_i(br_start),
		.npc_i(issue_i.npc),
		.opa_i(issue_i.ra),
		.inst_i(issue_i.inst),
		.rob_idx_i(issue_i.rob_idx),
		.done_o(br_done),
		.result_o(br_res)
	);

	mult_ctrl u_mult_ctrl (
		.clk(clk),
		.rst(rst),
		.start_i(mult_start),
		.last_step_i(mult_last),
		.load_o(mult_load),
		.step_o(mult_step),
		.done_o(mult_done),
		.busy_o(fu2rs_mult_busy_o),
		.issue_block_o(fu2rs_issue_block_o)
	);

	mult_step_counter u_mult_step_counter (
		.clk(clk),
		.rst(rst),
		.load_i(mult_load),
		.step_i(mult_step),
		.last_step_o(mult_last)
	);

	mult_datapath u_mult_datapath (
		.clk(clk),
		.load_i(mult_load),
		.step_i(mult_step),
		.opa_i(issue_i.ra),
		.opb_i(issue_i.rb),
		.dest_tag_i(issue_i.dest_tag),
		.rob_idx_i(issue_i.rob_idx),
		.result_o(mult_res)
	);

	// The issue rules keep the done strobes one-hot.
	always_comb begin
		done_res = '0;
		if (alu_done) begin
			done_res = alu_res;
		end
		if (br_done) begin
			done_res = br_res;
		end
		if (mult_done) begin
			done_res = mult_res;
		end
	end

	assign fu2preg_wr_en_o = alu_done | mult_done;
	assign fu2preg_wr_o.idx = done_res.dest_tag;
	assign fu2preg_wr_o.value = done_res.value;

	assign fu2rob_done_o = alu_done | br_done | mult_done;
	assign fu2rob_o.rob_idx = done_res.rob_idx;
	assign fu2rob_o.br_taken = done_res.br_taken;
	assign fu2rob_o.br_target = done_res.br_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			fu_cdb_valid_o <= 1'b0;
		end else begin
			fu_cdb_valid_o <= fu2preg_wr_en_o;
		end
	end

	always_ff @(posedge clk) begin
		fu_cdb_tag_o <= fu2preg_wr_o.idx;
	end

endmodule

// ==== verilog/fu_pkg.sv ====
package fu_pkg;

	localparam int WORD_W = 64;
	localparam int INST_W = 32;
	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int FU_SEL_W = 3;
	localparam int ALU_FUNC_W = 7;
	localparam int BR_COND_W = 3;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [INST_W-1:0] inst_t;
	typedef logic [PRF_IDX_W-1:0] prf_idx_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [FU_SEL_W-1:0] fu_sel_t;
	typedef logic [ALU_FUNC_W-1:0] alu_func_t;
	typedef logic [BR_COND_W-1:0] br_cond_t;

	// Unit select codes from the issue stage.
	localparam fu_sel_t FU_SEL_NONE = 3'd0;
	localparam fu_sel_t FU_SEL_ALU = 3'd1;
	localparam fu_sel_t FU_SEL_BR = 3'd2;
	localparam fu_sel_t FU_SEL_MULT = 3'd3;
	localparam fu_sel_t FU_SEL_LOAD = 3'd4;
	localparam fu_sel_t FU_SEL_STORE = 3'd5;

	// ALU function field, instruction bits 11 to 5.
	localparam alu_func_t ALU_ADD = 7'h20;
	localparam alu_func_t ALU_SUB = 7'h29;
	localparam alu_func_t ALU_AND = 7'h00;
	localparam alu_func_t ALU_OR = 7'h08;
	localparam alu_func_t ALU_XOR = 7'h40;
	localparam alu_func_t ALU_SLL = 7'h39;
	localparam alu_func_t ALU_SRL = 7'h34;
	localparam alu_func_t ALU_SRA = 7'h3c;
	localparam alu_func_t ALU_CMPEQ = 7'h2d;
	localparam alu_func_t ALU_CMPULT = 7'h1d;

	// Branch condition field, instruction bits 28 to 26.
	localparam br_cond_t BR_ALWAYS = 3'd0;
	localparam br_cond_t BR_EQ = 3'd1;
	localparam br_cond_t BR_NE = 3'd2;
	localparam br_cond_t BR_LT = 3'd3;
	localparam br_cond_t BR_GE = 3'd4;

	// Two multiplier bits are retired per step.
	localparam int MULT_STEPS = 32;
	localparam int MULT_CNT_W = $clog2(MULT_STEPS);

	typedef logic [MULT_CNT_W-1:0] mult_cnt_t;

	typedef enum logic [1:0] {
		MULT_IDLE,
		MULT_RUN,
		MULT_WB
	} mult_state_e;

	typedef struct packed {
		word_t npc;
		rob_idx_t rob_idx;
		word_t ra;
		word_t rb;
		prf_idx_t dest_tag;
		inst_t inst;
		fu_sel_t sel;
	} fu_issue_t;

	typedef struct packed {
		word_t value;
		prf_idx_t dest_tag;
		rob_idx_t rob_idx;
		logic br_taken;
		word_t br_target;
	} fu_result_t;

	typedef struct packed {
		prf_idx_t idx;
		word_t value;
	} fu_wb_t;

	typedef struct packed {
		rob_idx_t rob_idx;
		logic br_taken;
		word_t br_target;
	} fu_rob_t;

endpackage

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
	input logic clk,
	input logic rst,
	input logic start_i,
	input fu_pkg::word_t opa_i,
	input fu_pkg::word_t opb_i,
	input fu_pkg::inst_t inst_i,
	input fu_pkg::prf_idx_t dest_tag_i,
	input fu_pkg::rob_idx_t rob_idx_i,
	output logic done_o,
	output fu_pkg::fu_result_t result_o
);
	import fu_pkg::*;

	alu_func_t func;
	logic [5:0] shamt;
	word_t value_nxt;
	word_t value_r;
	prf_idx_t dest_tag_r;
	rob_idx_t rob_idx_r;

	assign func = inst_i[11:5];
	assign shamt = opb_i[5:0];

	always_comb begin
		case (func)
			ALU_ADD: value_nxt = opa_i + opb_i;
			ALU_SUB: value_nxt = opa_i - opb_i;
			ALU_AND: value_nxt = opa_i & opb_i;
			ALU_OR: value_nxt = opa_i | opb_i;
			ALU_XOR: value_nxt = opa_i ^ opb_i;
			ALU_SLL: value_nxt = opa_i << shamt;
			ALU_SRL: value_nxt = opa_i >> shamt;
			ALU_SRA: value_nxt = word_t'($signed(opa_i) >>> shamt);
			ALU_CMPEQ: value_nxt = {{(WORD_W-1){1'b0}}, opa_i == opb_i};
			ALU_CMPULT: value_nxt = {{(WORD_W-1){1'b0}}, opa_i < opb_i};
			default: value_nxt = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			value_r <= value_nxt;
			dest_tag_r <= dest_tag_i;
			rob_idx_r <= rob_idx_i;
		end
	end

	// ALU completions never carry branch information.
	always_comb begin
		result_o.value = value_r;
		result_o.dest_tag = dest_tag_r;
		result_o.rob_idx = rob_idx_r;
		result_o.br_taken = 1'b0;
		result_o.br_target = '0;
	end

endmodule

// ==== verilog/mult_ctrl.sv ====
`timescale 1ns/1ps

module mult_ctrl (
	input logic clk,
	input logic rst,
	input logic start_i,
	input logic last_step_i,
	output logic load_o,
	output logic step_o,
	output logic done_o,
	output logic busy_o,
	output logic issue_block_o
);
	import fu_pkg::*;

	mult_state_e state;
	mult_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			MULT_IDLE: begin
				if (start_i) begin
					state_nxt = MULT_RUN;
				end
			end
			MULT_RUN: begin
				if (last_step_i) begin
					state_nxt = MULT_WB;
				end
			end
			MULT_WB: state_nxt = MULT_IDLE;
			default: state_nxt = MULT_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MULT_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign load_o = start_i && (state == MULT_IDLE);
	assign step_o = (state == MULT_RUN);
	assign done_o = (state == MULT_WB);
	assign busy_o = (state != MULT_IDLE);

	// A one-cycle unit issued now would finish in the WB cycle, so hold it off.
	assign issue_block_o = (state == MULT_RUN) && last_step_i;

endmodule

// ==== verilog/mult_datapath.sv ====
`timescale 1ns/1ps

module mult_datapath (
	input logic clk,
	input logic load_i,
	input logic step_i,
	input fu_pkg::word_t opa_i,
	input fu_pkg::word_t opb_i,
	input fu_pkg::prf_idx_t dest_tag_i,
	input fu_pkg::rob_idx_t rob_idx_i,
	output fu_pkg::fu_result_t result_o
);
	import fu_pkg::*;

	word_t mcand;
	word_t mplier;
	word_t acc;
	word_t partial;
	prf_idx_t dest_tag_r;
	rob_idx_t rob_idx_r;

	// Multiplicand times the two low multiplier bits.
	always_comb begin
		partial = '0;
		if (mplier[0]) begin
			partial = partial + mcand;
		end
		if (mplier[1]) begin
			partial = partial + (mcand << 1);
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			mcand <= opa_i;
			mplier <= opb_i;
			acc <= '0;
			dest_tag_r <= dest_tag_i;
			rob_idx_r <= rob_idx_i;
		end else if (step_i) begin
			acc <= acc + partial;
			mcand <= mcand << 2;
			mplier <= mplier >> 2;
		end
	end

	always_comb begin
		result_o.value = acc;
		result_o.dest_tag = dest_tag_r;
		result_o.rob_idx = rob_idx_r;
		result_o.br_taken = 1'b0;
		result_o.br_target = '0;
	end

endmodule

// ==== verilog/mult_step_counter.sv ====
`timescale 1ns/1ps

module mult_step_counter (
	input logic clk,
	input logic rst,
	input logic load_i,
	input logic step_i,
	output logic last_step_o
);
	import fu_pkg::*;

	mult_cnt_t cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (load_i) begin
			cnt <= mult_cnt_t'(MULT_STEPS - 1);
		end else if (step_i) begin
			cnt <= cnt - 1'b1;
		end
	end

	// Zero is reached in the last of the 32 run cycles.
	assign last_step_o = (cnt == '0);

endmodule
